//--- ads1292_ctrl.f
hw/ads_pkg.sv
hw/spi_byte_if.sv
hw/spi_byte_engine.sv
hw/ads_frame_sequencer.sv
hw/ads1292_ctrl.sv
bench/ads1292_ctrl_assertions.sv
bench/tb_ads1292_ctrl.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ads1292_ctrl
FILELIST  ?= ads1292_ctrl.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only when the pass line shows up in the simulator output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/tb_ads1292_ctrl.sv
`timescale 1ns/1ns

module tb_ads1292_ctrl;

	localparam int CLK_NS   = 8;
	localparam int HALF_BIT = 2; // fast sclk
	localparam int CS_HOLD  = 8;
	localparam int NUM_OPS  = 200;
	localparam int OP_CLKS  = 3 * 16 * HALF_BIT + CS_HOLD + 20; // longest op plus slack
	localparam longint WATCHDOG_NS = 2 * NUM_OPS * OP_CLKS * CLK_NS;

	logic                       i_CLK;
	logic                       i_RSTN;
	logic [ads_pkg::ctrl_w-1:0] i_ads_control;
	logic [ads_pkg::byte_w-1:0] i_ads_command;
	logic [ads_pkg::byte_w-1:0] i_ads_reg_addr;
	logic [ads_pkg::byte_w-1:0] i_ads_data_in;
	logic [ads_pkg::byte_w-1:0] o_ads_rreg_data;
	logic                       o_ads_busy;
	logic                       o_spi_clk;
	logic                       i_spi_miso;
	logic                       o_spi_mosi;
	logic                       o_ads_start;
	logic                       o_ads_resetn;
	logic                       o_spi_csn;

	logic [7:0] regs [32];   // slave register model
	logic [7:0] rx_q [$];    // every byte seen by the slave
	logic [7:0] shreg;
	logic [7:0] first_byte;  // opcode byte of current frame
	logic [2:0] bit_sel;
	logic       sclk_prev;
	logic       csn_prev;
	int         bit_cnt;
	int         byte_idx;
	int         sclk_edges;
	time        last_fall_t;
	time        csn_rise_t;
	int         seed;
	int         checks;
	int         error_cnt;

	ads1292_ctrl #(.CLKS_PER_HALF_BIT(HALF_BIT), .CS_HOLD_CLKS(CS_HOLD)) uut (.*);

	initial begin
		i_CLK = 1'b0;
		forever #(CLK_NS / 2) i_CLK = ~i_CLK;
	end

	// ====================================================================
	// ads1292 slave, mode 1, din sampled on falling sclk
	// ====================================================================
	function automatic logic [7:0] reset_val(input logic [4:0] a);
		return {a[2:0], a} ^ 8'h96; // all five address bits matter
	endfunction

	initial begin
		i_spi_miso = 1'b0;
		sclk_prev  = 1'b0;
		csn_prev   = 1'b1;
		bit_cnt    = 0;
		byte_idx   = 0;
		sclk_edges = 0;
		first_byte = 8'h00;
		for (int a = 0; a < 32; a++)
			regs[a] = reset_val(5'(a));
		forever begin
			@(o_spi_clk or o_spi_csn);
			if (o_spi_csn !== 1'b0) begin
				if (!csn_prev)
					csn_rise_t = $time; // frame over
				bit_cnt    = 0;
				byte_idx   = 0;
				i_spi_miso = 1'b0;
			end else if (o_spi_clk !== sclk_prev) begin
				sclk_edges++;
				if (o_spi_clk) begin
					// dout changes on rising sclk, read data during 3rd byte
					bit_sel = 3'(7 - bit_cnt);
					if (byte_idx == 2 && first_byte[7:5] == ads_pkg::OP_RREG)
						i_spi_miso = regs[first_byte[4:0]][bit_sel];
					else
						i_spi_miso = 1'b0;
				end else begin
					shreg = {shreg[6:0], o_spi_mosi};
					bit_cnt++;
					last_fall_t = $time;
					if (bit_cnt == 8) begin
						rx_q.push_back(shreg);
						if (byte_idx == 0)
							first_byte = shreg;
						if (byte_idx == 2 && first_byte[7:5] == ads_pkg::OP_WREG)
							regs[first_byte[4:0]] = shreg; // wreg data byte
						byte_idx++;
						bit_cnt = 0;
					end
				end
			end
			sclk_prev = o_spi_clk;
			csn_prev  = o_spi_csn;
		end
	end

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		assert (got === exp) else begin
			error_cnt++;
			$display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// one host operation, hands control back to idle once busy shows
	task automatic do_op(input logic [2:0] ctrl, input logic [7:0] cmd,
		input logic [7:0] addr, input logic [7:0] data);
		int         start_idx;
		int         start_edges;
		int         cnt;
		int         busy_cycles;
		bit         saw_rst;
		logic [7:0] exp_q [$];
		start_idx   = rx_q.size();
		start_edges = sclk_edges;
		@(posedge i_CLK);
		#1;
		i_ads_control  = ctrl;
		i_ads_command  = cmd;
		i_ads_reg_addr = addr;
		i_ads_data_in  = data;
		if (ctrl == ads_pkg::CB_IDLE || ctrl > ads_pkg::CB_RREG) begin
			repeat (4) begin
				@(posedge i_CLK);
				#1;
				check_byte("o_ads_busy", 8'(o_ads_busy), 8'd0); // unused code is idle
			end
			i_ads_control = ads_pkg::CB_IDLE;
			return;
		end
		cnt = 0;
		while (!o_ads_busy && cnt < 8) begin
			@(posedge i_CLK);
			#1;
			cnt++;
		end
		check_byte("busy rise latency", 8'(cnt), 8'd2);
		i_ads_control = ads_pkg::CB_IDLE;
		busy_cycles   = 0;
		saw_rst       = 1'b0;
		while (o_ads_busy && busy_cycles < OP_CLKS) begin
			if (!o_ads_resetn)
				saw_rst = 1'b1;
			@(posedge i_CLK);
			#1;
			busy_cycles++;
		end
		assert (!o_ads_busy) else begin
			error_cnt++;
			$display("busy never fell for control %0d command %h", ctrl, cmd);
		end
		if (ctrl == ads_pkg::CB_SYSCMD && (cmd == ads_pkg::CM_START ||
			cmd == ads_pkg::CM_STOP || cmd == ads_pkg::CM_RESET)) begin
			assert (busy_cycles >= 2 && busy_cycles <= 3) else begin
				error_cnt++;
				$display("pin command %h kept busy for %0d cycles", cmd, busy_cycles);
			end
			check_byte("sclk edges", 8'(sclk_edges - start_edges), 8'd0);
			if (cmd == ads_pkg::CM_START)
				check_byte("o_ads_start", 8'(o_ads_start), 8'd1);
			else if (cmd == ads_pkg::CM_STOP)
				check_byte("o_ads_start", 8'(o_ads_start), 8'd0);
			else
				assert (saw_rst) else begin
					error_cnt++;
					$display("o_ads_resetn never went low during RESET");
				end
		end else begin
			if (ctrl == ads_pkg::CB_SYSCMD) begin
				exp_q.push_back(cmd);
			end else begin
				exp_q.push_back({(ctrl == ads_pkg::CB_WREG) ? ads_pkg::OP_WREG :
					ads_pkg::OP_RREG, addr[4:0]});
				exp_q.push_back(ads_pkg::OP_NUM_REG);
				exp_q.push_back((ctrl == ads_pkg::CB_WREG) ? data : 8'h00); // dummy on read
			end
			check_byte("frame length", 8'(rx_q.size() - start_idx), 8'(exp_q.size()));
			foreach (exp_q[i])
				if (start_idx + i < rx_q.size())
					check_byte($sformatf("frame byte %0d", i), rx_q[start_idx + i], exp_q[i]);
			assert (csn_rise_t - last_fall_t >= time'(CS_HOLD * CLK_NS)) else begin
				error_cnt++;
				$display("csn released %0t after last sclk edge", csn_rise_t - last_fall_t);
			end
			if (ctrl == ads_pkg::CB_WREG)
				check_byte("slave register", regs[addr[4:0]], data);
			if (ctrl == ads_pkg::CB_RREG)
				check_byte("o_ads_rreg_data", o_ads_rreg_data, regs[addr[4:0]]);
		end
		@(posedge i_CLK);
		#1;
		check_byte("o_spi_csn", 8'(o_spi_csn), 8'd1); // deselected one cycle later at most
	endtask

	// ====================================================================
	// stimulus
	// ====================================================================
	initial begin
		logic [31:0] r;
		logic [31:0] d;
		logic [2:0]  ctrl;
		logic [7:0]  cmd;
		checks         = 0;
		error_cnt      = 0;
		seed           = 32'hc0778d4c;
		i_RSTN         = 1'b0;
		i_ads_control  = ads_pkg::CB_IDLE;
		i_ads_command  = 8'h00;
		i_ads_reg_addr = 8'h00;
		i_ads_data_in  = 8'h00;
		repeat (8) @(posedge i_CLK);
		#1 i_RSTN = 1'b1;
		@(posedge i_CLK);
		#1;
		check_byte("o_ads_busy", 8'(o_ads_busy), 8'd0);
		check_byte("o_spi_csn", 8'(o_spi_csn), 8'd1);
		check_byte("o_ads_start", 8'(o_ads_start), 8'd0);
		check_byte("o_ads_resetn", 8'(o_ads_resetn), 8'd1);
		check_byte("o_spi_clk", 8'(o_spi_clk), 8'd0);
		check_byte("o_ads_rreg_data", o_ads_rreg_data, 8'h00);

		// fixed opening
		do_op(ads_pkg::CB_SYSCMD, ads_pkg::CM_START, 8'h00, 8'h00);
		do_op(ads_pkg::CB_SYSCMD, ads_pkg::CM_STOP, 8'h00, 8'h00);
		do_op(ads_pkg::CB_SYSCMD, ads_pkg::CM_RESET, 8'h00, 8'h00);
		do_op(ads_pkg::CB_SYSCMD, 8'h11, 8'h00, 8'h00);
		do_op(ads_pkg::CB_WREG, 8'h00, 8'h01, 8'hA5);
		do_op(ads_pkg::CB_RREG, 8'h00, 8'h01, 8'h00);
		do_op(ads_pkg::CB_RREG, 8'h00, 8'hE5, 8'h00); // upper address bits ignored
		do_op(3'd5, 8'h00, 8'h00, 8'h00);

		repeat (NUM_OPS) begin
			r = $random(seed);
			d = $random(seed);
			if (r[3:0] == 4'd0)
				ctrl = {1'b1, r[5:4]}; // unused codes
			else
				ctrl = 3'(r[3:0] % 4'd3) + 3'd1;
			if (r[8:7] == 2'd0)
				cmd = (r[10:9] == 2'd0) ? ads_pkg::CM_START :
					(r[10:9] == 2'd1) ? ads_pkg::CM_STOP : ads_pkg::CM_RESET;
			else
				cmd = r[23:16];
			do_op(ctrl, cmd, r[31:24], d[7:0]);
		end

		$display("checks %0d, errors %0d, assertion failures %0d",
			checks, error_cnt, uut.u_assertions.fail_cnt);
		if (error_cnt == 0 && uut.u_assertions.fail_cnt == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout, run went past %0d ns", WATCHDOG_NS);
		$display("checks %0d, errors %0d, assertion failures %0d",
			checks, error_cnt, uut.u_assertions.fail_cnt);
		$display("test failed");
		$finish;
	end

endmodule

//--- bench/ads1292_ctrl_assertions.sv
`timescale 1ns/1ns

module ads1292_ctrl_assertions #(
	parameter int CLKS_PER_HALF_BIT = 25,
	parameter int CS_HOLD_CLKS      = 197
) (
	input logic i_CLK,
	input logic i_RSTN,
	input logic i_ads_busy,
	input logic i_spi_csn,
	input logic i_spi_clk,
	input logic i_spi_mosi
);

	// three bytes with shifter and fsm overhead, then the csn hold
	localparam int BUSY_MAX = 3 * (16 * CLKS_PER_HALF_BIT + 4) + CS_HOLD_CLKS + 4;

	int r_busy_cnt;   // consecutive busy cycles
	int fail_cnt = 0; // assertion failures so far

	always_ff @(posedge i_CLK or negedge i_RSTN) begin
		if (!i_RSTN)
			r_busy_cnt <= 0;
		else if (i_ads_busy)
			r_busy_cnt <= r_busy_cnt + 1;
		else
			r_busy_cnt <= 0;
	end

	// ====================================================================
	// protocol properties
	// ====================================================================
	// csn may trail busy by one cycle after a pin command
	a_csn_idle : assert property (@(posedge i_CLK) disable iff (!i_RSTN)
		(!i_ads_busy && !$past(i_ads_busy)) |-> i_spi_csn)
		else begin
			fail_cnt++;
			$error("csn low while controller idle");
		end

	a_sclk_idle : assert property (@(posedge i_CLK) disable iff (!i_RSTN)
		i_spi_csn |-> !i_spi_clk)
		else begin
			fail_cnt++;
			$error("sclk toggles with csn high");
		end

	a_busy_bound : assert property (@(posedge i_CLK) disable iff (!i_RSTN)
		r_busy_cnt <= BUSY_MAX)
		else begin
			fail_cnt++;
			$error("busy high for too long");
		end

	a_mosi_stable : assert property (@(posedge i_CLK) disable iff (!i_RSTN)
		(!i_spi_clk && !$past(i_spi_clk)) |-> $stable(i_spi_mosi))
		else begin
			fail_cnt++;
			$error("mosi changed while sclk low");
		end

endmodule

bind ads1292_ctrl ads1292_ctrl_assertions #(
	.CLKS_PER_HALF_BIT (CLKS_PER_HALF_BIT),
	.CS_HOLD_CLKS      (CS_HOLD_CLKS)
) u_assertions (
	.i_CLK      (i_CLK),
	.i_RSTN     (i_RSTN),
	.i_ads_busy (o_ads_busy),
	.i_spi_csn  (o_spi_csn),
	.i_spi_clk  (o_spi_clk),
	.i_spi_mosi (o_spi_mosi)
);

//--- hw/ads1292_ctrl.sv
`timescale 1ns/1ns

module ads1292_ctrl #(
	parameter int CLKS_PER_HALF_BIT = 25,  // sclk = clk / (2 * this)
	parameter int CS_HOLD_CLKS      = 197  // csn low after frame
) (
	input  logic                       i_CLK,
	input  logic                       i_RSTN,

	// host side
	input  logic [ads_pkg::ctrl_w-1:0] i_ads_control,
	input  logic [ads_pkg::byte_w-1:0] i_ads_command,
	input  logic [ads_pkg::byte_w-1:0] i_ads_reg_addr,
	input  logic [ads_pkg::byte_w-1:0] i_ads_data_in,
	output logic [ads_pkg::byte_w-1:0] o_ads_rreg_data,
	output logic                       o_ads_busy,

	// ads1292 side
	output logic                       o_spi_clk,
	input  logic                       i_spi_miso, // chip DOUT
	output logic                       o_spi_mosi, // chip DIN
	output logic                       o_ads_start,
	output logic                       o_ads_resetn,
	output logic                       o_spi_csn
);

	spi_byte_if u_spi_if ();

	// host control to byte requests and pins
	ads_frame_sequencer #(
		.CS_HOLD_CLKS (CS_HOLD_CLKS)
	) u_sequencer (
		.i_CLK           (i_CLK),
		.i_RSTN          (i_RSTN),
		.i_ads_control   (i_ads_control),
		.i_ads_command   (i_ads_command),
		.i_ads_reg_addr  (i_ads_reg_addr),
		.i_ads_data_in   (i_ads_data_in),
		.o_ads_rreg_data (o_ads_rreg_data),
		.o_ads_busy      (o_ads_busy),
		.o_ads_start     (o_ads_start),
		.o_ads_resetn    (o_ads_resetn),
		.o_spi_csn       (o_spi_csn),
		.spi             (u_spi_if.sequencer)
	);

	// mode 1 shifter
	spi_byte_engine #(
		.CLKS_PER_HALF_BIT (CLKS_PER_HALF_BIT)
	) u_engine (
		.i_CLK      (i_CLK),
		.i_RSTN     (i_RSTN),
		.spi        (u_spi_if.engine),
		.i_spi_miso (i_spi_miso),
		.o_spi_clk  (o_spi_clk),
		.o_spi_mosi (o_spi_mosi)
	);

endmodule

//--- hw/ads_frame_sequencer.sv
`timescale 1ns/1ns

module ads_frame_sequencer #(
	parameter int CS_HOLD_CLKS = 197 // csn low time after last byte
) (
	input  logic                        i_CLK,
	input  logic                        i_RSTN,
	input  logic [ads_pkg::ctrl_w-1:0]  i_ads_control,
	input  logic [ads_pkg::byte_w-1:0]  i_ads_command,
	input  logic [ads_pkg::byte_w-1:0]  i_ads_reg_addr,
	input  logic [ads_pkg::byte_w-1:0]  i_ads_data_in,
	output logic [ads_pkg::byte_w-1:0]  o_ads_rreg_data,
	output logic                        o_ads_busy,
	output logic                        o_ads_start,
	output logic                        o_ads_resetn,
	output logic                        o_spi_csn,
	spi_byte_if.sequencer               spi
);

	localparam int HOLD_W = $clog2(CS_HOLD_CLKS + 1);

	// fsm encoding
	localparam logic [2:0] ST_IDLE     = 3'd0;
	localparam logic [2:0] ST_DECODE   = 3'd1; // pins or spi frame
	localparam logic [2:0] ST_PIN_DONE = 3'd2; // pin command applied
	localparam logic [2:0] ST_ISSUE    = 3'd3; // hand byte to shifter
	localparam logic [2:0] ST_WAIT     = 3'd4; // byte on the wire
	localparam logic [2:0] ST_HOLD     = 3'd5; // csn hold after frame

	logic [ads_pkg::ctrl_w-1:0]     r_mode; // decoded host control
	logic [ads_pkg::ctrl_w-1:0]     r_op;   // operation in progress
	logic [2:0]                     r_state;
	logic [ads_pkg::byte_w-1:0]     r_command;
	logic [ads_pkg::reg_addr_w-1:0] r_reg_addr;
	logic [ads_pkg::byte_w-1:0]     r_data_in;
	logic [1:0]                     r_byte_idx; // byte within frame
	logic [1:0]                     r_last_idx; // 0 for command, 2 for register
	logic [HOLD_W-1:0]              r_hold_cnt;
	logic [ads_pkg::byte_w-1:0]     w_frame_byte;
	logic                           w_pin_cmd;

	// ====================================================================
	// host control decode
	// ====================================================================
	always_ff @(posedge i_CLK or negedge i_RSTN) begin
		if (!i_RSTN)
			r_mode <= ads_pkg::CB_IDLE;
		else if (i_ads_control > ads_pkg::CB_RREG)
			r_mode <= ads_pkg::CB_IDLE; // unused codes
		else
			r_mode <= i_ads_control;
	end

	// host bytes follow the inputs while idle, frozen once busy
	always_ff @(posedge i_CLK) begin
		if (r_state == ST_IDLE) begin
			r_command  <= i_ads_command;
			r_reg_addr <= i_ads_reg_addr[ads_pkg::reg_addr_w-1:0]; // upper bits unused
			r_data_in  <= i_ads_data_in;
		end
	end

	assign w_pin_cmd = (r_command == ads_pkg::CM_START) ||
		(r_command == ads_pkg::CM_STOP) ||
		(r_command == ads_pkg::CM_RESET);

	// ====================================================================
	// frame contents
	// ====================================================================
	always_comb begin
		case (r_byte_idx)
			2'd0: begin
				if (r_op == ads_pkg::CB_SYSCMD)
					w_frame_byte = r_command; // plain command byte
				else if (r_op == ads_pkg::CB_WREG)
					w_frame_byte = {ads_pkg::OP_WREG, r_reg_addr};
				else
					w_frame_byte = {ads_pkg::OP_RREG, r_reg_addr};
			end
			2'd1: w_frame_byte = ads_pkg::OP_NUM_REG; // one register
			default: begin
				if (r_op == ads_pkg::CB_WREG)
					w_frame_byte = r_data_in;
				else
					w_frame_byte = '0; // dummy, clocks the read data out
			end
		endcase
	end

	assign spi.tx_byte  = w_frame_byte;
	assign spi.tx_valid = (r_state == ST_ISSUE) & spi.tx_ready; // single cycle

	// ====================================================================
	// frame fsm
	// ====================================================================
	always_ff @(posedge i_CLK or negedge i_RSTN) begin
		if (!i_RSTN) begin
			r_state         <= ST_IDLE;
			r_op            <= ads_pkg::CB_IDLE;
			r_byte_idx      <= 2'd0;
			r_last_idx      <= 2'd0;
			r_hold_cnt      <= '0;
			o_ads_busy      <= 1'b0;
			o_spi_csn       <= 1'b1;
			o_ads_start     <= 1'b0;
			o_ads_resetn    <= 1'b1;
			o_ads_rreg_data <= '0;
		end else begin
			case (r_state)
				ST_IDLE: begin
					o_ads_resetn <= 1'b1; // reset pulse ends here
					o_ads_busy   <= 1'b0;
					o_spi_csn    <= 1'b1;
					r_byte_idx   <= 2'd0;
					r_op         <= r_mode;
					if (r_mode != ads_pkg::CB_IDLE) begin
						o_ads_busy <= 1'b1;
						o_spi_csn  <= 1'b0; // select chip with busy
						r_state    <= ST_DECODE;
					end
				end

				ST_DECODE: begin
					if ((r_op == ads_pkg::CB_SYSCMD) && w_pin_cmd) begin
						// start/stop/reset go out on pins only
						if (r_command == ads_pkg::CM_START)
							o_ads_start <= 1'b1;
						else if (r_command == ads_pkg::CM_STOP)
							o_ads_start <= 1'b0;
						else
							o_ads_resetn <= 1'b0;
						r_state <= ST_PIN_DONE;
					end else begin
						r_last_idx <= (r_op == ads_pkg::CB_SYSCMD) ? 2'd0 : 2'd2;
						r_state    <= ST_ISSUE;
					end
				end

				ST_PIN_DONE: begin
					o_ads_busy <= 1'b0; // csn follows in idle
					r_state    <= ST_IDLE;
				end

				ST_ISSUE: begin
					if (spi.tx_ready)
						r_state <= ST_WAIT; // tx_valid pulsed this cycle
				end

				ST_WAIT: begin
					// read data comes back during the dummy byte
					if (spi.rx_valid && (r_op == ads_pkg::CB_RREG) && (r_byte_idx == 2'd2))
						o_ads_rreg_data <= spi.rx_byte;

					if (spi.tx_ready) begin
						if (r_byte_idx == r_last_idx) begin
							r_hold_cnt <= '0;
							r_state    <= ST_HOLD;
						end else begin
							r_byte_idx <= r_byte_idx + 1'b1;
							r_state    <= ST_ISSUE;
						end
					end
				end

				ST_HOLD: begin
					if (r_hold_cnt == HOLD_W'(CS_HOLD_CLKS - 1)) begin
						o_spi_csn  <= 1'b1; // deselect and finish together
						o_ads_busy <= 1'b0;
						r_state    <= ST_IDLE;
					end else begin
						r_hold_cnt <= r_hold_cnt + 1'b1;
					end
				end

				default: r_state <= ST_IDLE;
			endcase
		end
	end

endmodule

//--- hw/spi_byte_engine.sv
`timescale 1ns/1ns

module spi_byte_engine #(
	parameter int CLKS_PER_HALF_BIT = 25 // sys clocks per sclk half period, >= 2
) (
	input  logic       i_CLK,
	input  logic       i_RSTN,
	spi_byte_if.engine spi,
	input  logic       i_spi_miso,
	output logic       o_spi_clk,
	output logic       o_spi_mosi
);

	localparam int HALF_W = $clog2(CLKS_PER_HALF_BIT);
	localparam int EDGES  = 2 * ads_pkg::byte_w; // 16 sclk edges per byte
	localparam int EDGE_W = $clog2(EDGES + 1);

	logic [HALF_W-1:0]          r_half_cnt; // clocks inside current half bit
	logic [EDGE_W-1:0]          r_edge_cnt; // sclk edges still to go
	logic                       r_sclk;
	logic                       r_tx_ready;
	logic                       r_rx_valid;
	logic                       r_mosi;
	logic [ads_pkg::byte_w-1:0] r_tx_shift;
	logic [ads_pkg::byte_w-1:0] r_rx_shift;
	logic [ads_pkg::byte_w-1:0] r_rx_byte;
	logic                       w_start;
	logic                       w_half_done;
	logic                       w_rise;
	logic                       w_fall;
	logic                       w_last_fall;

	// ====================================================================
	// edge strobes
	// ====================================================================
	assign w_start     = spi.tx_valid & r_tx_ready;
	assign w_half_done = (r_edge_cnt != '0) &&
		(r_half_cnt == HALF_W'(CLKS_PER_HALF_BIT - 1));
	assign w_rise      = w_half_done & ~r_sclk; // mode 1, mosi changes here
	assign w_fall      = w_half_done & r_sclk;  // mode 1, miso sampled here
	assign w_last_fall = w_fall && (r_edge_cnt == EDGE_W'(1));

	// ====================================================================
	// sclk generation and handshake
	// ====================================================================
	always_ff @(posedge i_CLK or negedge i_RSTN) begin
		if (!i_RSTN) begin
			r_tx_ready <= 1'b1;
			r_edge_cnt <= '0;
			r_half_cnt <= '0;
			r_sclk     <= 1'b0; // cpol 0
			r_rx_valid <= 1'b0;
			r_mosi     <= 1'b0;
		end else begin
			r_rx_valid <= w_last_fall; // byte complete

			if (w_start) begin
				// new byte, start counting half bits
				r_tx_ready <= 1'b0;
				r_edge_cnt <= EDGE_W'(EDGES);
				r_half_cnt <= '0;
			end else if (r_edge_cnt != '0) begin
				if (w_half_done) begin
					r_half_cnt <= '0;
					r_edge_cnt <= r_edge_cnt - 1'b1;
					r_sclk     <= ~r_sclk;
				end else begin
					r_half_cnt <= r_half_cnt + 1'b1;
				end
			end else begin
				r_tx_ready <= 1'b1; // 8th bit period over
			end

			// msb first, put next bit out on the leading edge
			if (w_rise)
				r_mosi <= r_tx_shift[ads_pkg::byte_w-1];
		end
	end

	// shift registers, payload only
	always_ff @(posedge i_CLK) begin
		if (w_start)
			r_tx_shift <= spi.tx_byte;
		else if (w_rise)
			r_tx_shift <= {r_tx_shift[ads_pkg::byte_w-2:0], 1'b0};

		if (w_fall)
			r_rx_shift <= {r_rx_shift[ads_pkg::byte_w-2:0], i_spi_miso};

		if (w_last_fall)
			r_rx_byte <= {r_rx_shift[ads_pkg::byte_w-2:0], i_spi_miso}; // full byte incl last bit
	end

	assign spi.tx_ready = r_tx_ready;
	assign spi.rx_valid = r_rx_valid;
	assign spi.rx_byte  = r_rx_byte;
	assign o_spi_clk    = r_sclk;
	assign o_spi_mosi   = r_mosi;

endmodule

//--- hw/spi_byte_if.sv
`timescale 1ns/1ns

// one byte each way between the frame sequencer and the spi shifter
interface spi_byte_if;

	logic [ads_pkg::byte_w-1:0] tx_byte;  // byte to shift out on mosi
	logic                       tx_valid; // one cycle request, only while tx_ready
	logic                       tx_ready; // shifter idle, drops after tx_valid
	logic [ads_pkg::byte_w-1:0] rx_byte;  // byte sampled from miso
	logic                       rx_valid; // one cycle, after 8th falling edge

	// frame side
	modport sequencer (
		output tx_byte,
		output tx_valid,
		input  tx_ready,
		input  rx_byte,
		input  rx_valid
	);

	// shifter side
	modport engine (
		input  tx_byte,
		input  tx_valid,
		output tx_ready,
		output rx_byte,
		output rx_valid
	);

endinterface

//--- hw/ads_pkg.sv
package ads_pkg;

	// ====================================================================
	// host control codes
	// ====================================================================
	localparam int ctrl_w = 3; // width of host control code

	localparam logic [ctrl_w-1:0] CB_IDLE   = 3'd0; // nothing to do
	localparam logic [ctrl_w-1:0] CB_SYSCMD = 3'd1; // system command
	localparam logic [ctrl_w-1:0] CB_WREG   = 3'd2; // single register write
	localparam logic [ctrl_w-1:0] CB_RREG   = 3'd3; // single register read
	// codes 4..7 fall back to idle

	// ====================================================================
	// spi widths and ads1292 opcodes
	// ====================================================================
	localparam int byte_w     = 8; // one spi byte
	localparam int reg_addr_w = 5; // register address field in opcode

	// commands handled on the START and RESET pins, never sent
	localparam logic [byte_w-1:0] CM_RESET = 8'h06;
	localparam logic [byte_w-1:0] CM_START = 8'h08;
	localparam logic [byte_w-1:0] CM_STOP  = 8'h0A;

	// first opcode byte is {prefix, address}
	localparam logic [2:0] OP_RREG = 3'b001; // 001r_rrrr
	localparam logic [2:0] OP_WREG = 3'b010; // 010r_rrrr

	// second opcode byte, number of registers minus one
	localparam logic [byte_w-1:0] OP_NUM_REG = 8'h00; // one register

endpackage
